// ==== hw/rvv_pmtrdt_defines.svh ====
// widths and counts for the permutation/reduction path
// VLMAX must equal VLEN/SEW, and the station depth must be a power of two

`ifndef RVV_PMTRDT_DEFINES_SVH
`define RVV_PMTRDT_DEFINES_SVH

// execution units behind the station, unit 0 is the only compress unit
`define NUM_PMTRDT 2
// vector register width in bits, LMUL fixed at 1
`define VLEN 32
// element width
`define SEW 8
// elements per register
`define VLMAX 4
`define ROB_IDX_W 4
`define PMTRDT_RS_DEPTH 4

`endif

// ==== hw/rvv_pmtrdt_pkg.sv ====
// operation encoding shared by station, units and top
// one uop per operation, no masking through v0

`default_nettype none

package rvv_pmtrdt_pkg;

  // 3-bit opcode carried with each uop
  typedef enum logic [2:0] {
    // element-wise compares, mask in the low bits
    OP_VMSEQ     = 3'd0,
    OP_VMSLT     = 3'd1,
    // reductions seeded with vs1 element 0
    OP_VREDSUM   = 3'd2,
    OP_VREDMAX   = 3'd3,
    // pack vs2 under the vs1 mask, unit 0 only
    OP_VCOMPRESS = 3'd4
  } pmtrdt_op_e;

endpackage

`default_nettype wire

// ==== hw/rvv_pmtrdt_rs.sv ====
// reservation-station FIFO that exposes the two oldest entries to units 0 and 1
// entry 1 is held back when it is a compress
// pops must come in order

`default_nettype none

`include "rvv_pmtrdt_defines.svh"

module rvv_pmtrdt_rs (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          uop_valid,
  input  rvv_pmtrdt_pkg::pmtrdt_op_e                    uop_op,
  input  logic [`VLEN-1:0]                              uop_vs1,
  input  logic [`VLEN-1:0]                              uop_vs2,
  input  logic [`ROB_IDX_W-1:0]                         uop_rob_idx,
  output logic                                          uop_ready,
  output rvv_pmtrdt_pkg::pmtrdt_op_e [`NUM_PMTRDT-1:0]  rs_op,
  output logic [`NUM_PMTRDT-1:0][`VLEN-1:0]             rs_vs1,
  output logic [`NUM_PMTRDT-1:0][`VLEN-1:0]             rs_vs2,
  output logic [`NUM_PMTRDT-1:0][`ROB_IDX_W-1:0]        rs_rob_idx,
  output logic                                          fifo_empty,
  output logic [`NUM_PMTRDT-1:1]                        fifo_almost_empty,
  input  logic [`NUM_PMTRDT-1:0]                        rs_pop
);
  import rvv_pmtrdt_pkg::*;

  localparam int PTR_W = $clog2(`PMTRDT_RS_DEPTH);

  // entry storage
  pmtrdt_op_e              op_q     [`PMTRDT_RS_DEPTH];
  logic [`VLEN-1:0]        vs1_q    [`PMTRDT_RS_DEPTH];
  logic [`VLEN-1:0]        vs2_q    [`PMTRDT_RS_DEPTH];
  logic [`ROB_IDX_W-1:0]   rob_q    [`PMTRDT_RS_DEPTH];

  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  // one extra bit so full and empty differ
  logic [PTR_W:0]          count;
  logic                    push;
  logic [PTR_W:0]          pop_num;

  assign uop_ready  = (count != (PTR_W + 1)'(`PMTRDT_RS_DEPTH));
  assign push       = uop_valid & uop_ready;
  assign fifo_empty = (count == '0);

  // number of entries retired this cycle
  always_comb begin
    pop_num = '0;
    for (int i = 0; i < `NUM_PMTRDT; i++) begin
      pop_num = pop_num + {{PTR_W{1'b0}}, rs_pop[i]};
    end
  end

  // payload write on push
  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr]  <= uop_op;
      vs1_q[wr_ptr] <= uop_vs1;
      vs2_q[wr_ptr] <= uop_vs2;
      rob_q[wr_ptr] <= uop_rob_idx;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own at a power-of-two depth
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + pop_num[PTR_W-1:0];
      count  <= count + {{PTR_W{1'b0}}, push} - pop_num;
    end
  end

  // one entry per unit starting at the head
  for (genvar i = 0; i < `NUM_PMTRDT; i++) begin : gen_read
    logic [PTR_W-1:0] rd_idx;

    assign rd_idx        = rd_ptr + PTR_W'(i);
    assign rs_op[i]      = op_q[rd_idx];
    assign rs_vs1[i]     = vs1_q[rd_idx];
    assign rs_vs2[i]     = vs2_q[rd_idx];
    assign rs_rob_idx[i] = rob_q[rd_idx];

    if (i > 0) begin : gen_almost
      // too few entries or a compress that must wait for unit 0
      assign fifo_almost_empty[i] = (int'(count) <= i) | (rs_op[i] == OP_VCOMPRESS);
    end
  end

endmodule

`default_nettype wire

// ==== hw/rvv_pmtrdt_unit.sv ====
// two-stage compare/reduction unit, result two edges after accept
// compress gives zero unless COMPRESS is 1

`default_nettype none

`include "rvv_pmtrdt_defines.svh"

module rvv_pmtrdt_unit #(
  parameter bit COMPRESS = 1'b0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        uop_valid,
  input  rvv_pmtrdt_pkg::pmtrdt_op_e  uop_op,
  input  logic [`VLEN-1:0]            uop_vs1,
  input  logic [`VLEN-1:0]            uop_vs2,
  input  logic [`ROB_IDX_W-1:0]       uop_rob_idx,
  output logic                        uop_ready,
  output logic                        res_valid,
  output logic [`VLEN-1:0]            res_data,
  output logic [`ROB_IDX_W-1:0]       res_rob_idx,
  input  logic                        res_ready
);
  import rvv_pmtrdt_pkg::*;

  // stage 1, operands
  logic                    s1_valid;
  pmtrdt_op_e              s1_op;
  logic [`VLEN-1:0]        s1_vs1;
  logic [`VLEN-1:0]        s1_vs2;
  logic [`ROB_IDX_W-1:0]   s1_rob_idx;

  logic                    accept;
  logic                    s1_adv;
  logic [`VLMAX-1:0]       eq_mask;
  logic [`VLMAX-1:0]       lt_mask;
  logic [`SEW-1:0]         red_sum;
  logic signed [`SEW-1:0]  red_max;
  logic [`VLEN-1:0]        compress_data;
  logic [`VLEN-1:0]        s1_result;

  // stage 1 moves on when stage 2 is free or being drained
  assign s1_adv    = s1_valid & (~res_valid | res_ready);
  assign uop_ready = ~s1_valid | s1_adv;
  assign accept    = uop_valid & uop_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      if (accept) begin
        s1_valid <= 1'b1;
      end else if (s1_adv) begin
        s1_valid <= 1'b0;
      end
      if (s1_adv) begin
        res_valid <= 1'b1;
      end else if (res_ready) begin
        res_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_op      <= uop_op;
      s1_vs1     <= uop_vs1;
      s1_vs2     <= uop_vs2;
      s1_rob_idx <= uop_rob_idx;
    end
    // stage 2 holds while back-pressured
    if (s1_adv) begin
      res_data    <= s1_result;
      res_rob_idx <= s1_rob_idx;
    end
  end

  // compares and reduction trees
  always_comb begin
    red_sum = s1_vs1[`SEW-1:0];
    red_max = $signed(s1_vs1[`SEW-1:0]);
    for (int e = 0; e < `VLMAX; e++) begin
      eq_mask[e] = (s1_vs2[e*`SEW +: `SEW] == s1_vs1[e*`SEW +: `SEW]);
      // vs2 < vs1 as in vmslt.vv
      lt_mask[e] = ($signed(s1_vs2[e*`SEW +: `SEW]) < $signed(s1_vs1[e*`SEW +: `SEW]));
      // sum wraps at SEW
      red_sum = red_sum + s1_vs2[e*`SEW +: `SEW];
      if ($signed(s1_vs2[e*`SEW +: `SEW]) > red_max) begin
        red_max = $signed(s1_vs2[e*`SEW +: `SEW]);
      end
    end
  end

  if (COMPRESS) begin : gen_compress
    // packer, selected elements go low in ascending order
    always_comb begin
      logic [$clog2(`VLMAX):0] slot;
      slot          = '0;
      compress_data = '0;
      for (int e = 0; e < `VLMAX; e++) begin
        if (s1_vs1[e]) begin
          compress_data[slot*`SEW +: `SEW] = s1_vs2[e*`SEW +: `SEW];
          slot = slot + 1'b1;
        end
      end
    end
  end else begin : gen_no_compress
    // never routed a compress here
    assign compress_data = '0;
  end

  // result select, unused bits zero
  always_comb begin
    case (s1_op)
      OP_VMSEQ:     s1_result = {{(`VLEN-`VLMAX){1'b0}}, eq_mask};
      OP_VMSLT:     s1_result = {{(`VLEN-`VLMAX){1'b0}}, lt_mask};
      OP_VREDSUM:   s1_result = {{(`VLEN-`SEW){1'b0}}, red_sum};
      OP_VREDMAX:   s1_result = {{(`VLEN-`SEW){1'b0}}, red_max};
      OP_VCOMPRESS: s1_result = compress_data;
      default:      s1_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rvv_pmtrdt.sv ====
// execution wrapper, turns station status into unit valids and pops
// unit 1 issues only together with unit 0, so issue stays in order

`default_nettype none

`include "rvv_pmtrdt_defines.svh"

module rvv_pmtrdt (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  rvv_pmtrdt_pkg::pmtrdt_op_e [`NUM_PMTRDT-1:0]  rs_op,
  input  logic [`NUM_PMTRDT-1:0][`VLEN-1:0]             rs_vs1,
  input  logic [`NUM_PMTRDT-1:0][`VLEN-1:0]             rs_vs2,
  input  logic [`NUM_PMTRDT-1:0][`ROB_IDX_W-1:0]        rs_rob_idx,
  input  logic                                          fifo_empty,
  input  logic [`NUM_PMTRDT-1:1]                        fifo_almost_empty,
  output logic [`NUM_PMTRDT-1:0]                        rs_pop,
  output logic [`NUM_PMTRDT-1:0]                        res_valid,
  output logic [`NUM_PMTRDT-1:0][`VLEN-1:0]             res_data,
  output logic [`NUM_PMTRDT-1:0][`ROB_IDX_W-1:0]        res_rob_idx,
  input  logic [`NUM_PMTRDT-1:0]                        res_ready
);

  logic [`NUM_PMTRDT-1:0] unit_valid;
  logic [`NUM_PMTRDT-1:0] unit_ready;

  for (genvar i = 0; i < `NUM_PMTRDT; i++) begin : gen_unit
    if (i == 0) begin : gen_head
      // head entry goes to unit 0
      assign unit_valid[i] = ~fifo_empty;
    end else begin : gen_next
      // gate with the lower pop so no unit takes a uop the station keeps
      assign unit_valid[i] = ~fifo_almost_empty[i] & rs_pop[i-1];
    end

    // pop in the accept cycle
    assign rs_pop[i] = unit_valid[i] & unit_ready[i];

    // compress packer only in unit 0
    rvv_pmtrdt_unit #(
      .COMPRESS    ((i == 0) ? 1'b1 : 1'b0)
    ) u_pmtrdt_unit (
      .clk         (clk),
      .rst_n       (rst_n),
      .uop_valid   (unit_valid[i]),
      .uop_op      (rs_op[i]),
      .uop_vs1     (rs_vs1[i]),
      .uop_vs2     (rs_vs2[i]),
      .uop_rob_idx (rs_rob_idx[i]),
      .uop_ready   (unit_ready[i]),
      .res_valid   (res_valid[i]),
      .res_data    (res_data[i]),
      .res_rob_idx (res_rob_idx[i]),
      .res_ready   (res_ready[i])
    );
  end

endmodule

`default_nettype wire

// ==== hw/rvv_rob_wb_arb.sv ====
// round-robin merge of unit results onto the single ROB write port
// combinational grant that holds while the port stalls
// at least two units needed

`default_nettype none

`include "rvv_pmtrdt_defines.svh"

module rvv_rob_wb_arb (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [`NUM_PMTRDT-1:0]                  res_valid,
  input  logic [`NUM_PMTRDT-1:0][`VLEN-1:0]       res_data,
  input  logic [`NUM_PMTRDT-1:0][`ROB_IDX_W-1:0]  res_rob_idx,
  output logic [`NUM_PMTRDT-1:0]                  res_ready,
  output logic                                    result_valid,
  output logic [`VLEN-1:0]                        result_data,
  output logic [`ROB_IDX_W-1:0]                   result_rob_idx,
  input  logic                                    result_ready
);

  localparam int IDX_W = $clog2(`NUM_PMTRDT);

  // priority starts one past this unit
  logic [IDX_W-1:0] last_grant;
  logic [IDX_W-1:0] grant_idx;
  logic             grant_found;

  always_comb begin
    int cand;
    grant_idx   = last_grant;
    grant_found = 1'b0;
    for (int k = 1; k <= `NUM_PMTRDT; k++) begin
      cand = (int'(last_grant) + k) % `NUM_PMTRDT;
      if (!grant_found && res_valid[cand]) begin
        grant_idx   = IDX_W'(cand);
        grant_found = 1'b1;
      end
    end
  end

  assign result_valid   = grant_found;
  assign result_data    = res_data[grant_idx];
  assign result_rob_idx = res_rob_idx[grant_idx];

  // only the granted unit sees ready
  for (genvar i = 0; i < `NUM_PMTRDT; i++) begin : gen_ready
    assign res_ready[i] = result_ready & grant_found & (grant_idx == IDX_W'(i));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // unit 0 first after reset
      last_grant <= IDX_W'(`NUM_PMTRDT - 1);
    end else if (result_valid && result_ready) begin
      last_grant <= grant_idx;
    end else if (result_valid) begin
      // park one before the offered unit so it keeps the grant
      last_grant <= IDX_W'((int'(grant_idx) + `NUM_PMTRDT - 1) % `NUM_PMTRDT);
    end
  end

endmodule

`default_nettype wire

// ==== hw/rvv_pmtrdt_top.sv ====
// permutation/reduction path, station to units to ROB port
// results may leave out of order, rob_idx tags each one

`default_nettype none

`include "rvv_pmtrdt_defines.svh"

module rvv_pmtrdt_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        uop_valid,
  input  rvv_pmtrdt_pkg::pmtrdt_op_e  uop_op,
  input  logic [`VLEN-1:0]            uop_vs1,
  input  logic [`VLEN-1:0]            uop_vs2,
  input  logic [`ROB_IDX_W-1:0]       uop_rob_idx,
  output logic                        uop_ready,
  output logic                        result_valid,
  output logic [`VLEN-1:0]            result_data,
  output logic [`ROB_IDX_W-1:0]       result_rob_idx,
  input  logic                        result_ready
);
  import rvv_pmtrdt_pkg::*;

  // station to wrapper
  pmtrdt_op_e [`NUM_PMTRDT-1:0]                 rs_op;
  logic [`NUM_PMTRDT-1:0][`VLEN-1:0]            rs_vs1;
  logic [`NUM_PMTRDT-1:0][`VLEN-1:0]            rs_vs2;
  logic [`NUM_PMTRDT-1:0][`ROB_IDX_W-1:0]       rs_rob_idx;
  logic                                         fifo_empty;
  logic [`NUM_PMTRDT-1:1]                       fifo_almost_empty;
  logic [`NUM_PMTRDT-1:0]                       rs_pop;
  // units to arbiter
  logic [`NUM_PMTRDT-1:0]                       res_valid;
  logic [`NUM_PMTRDT-1:0][`VLEN-1:0]            res_data;
  logic [`NUM_PMTRDT-1:0][`ROB_IDX_W-1:0]       res_rob_idx;
  logic [`NUM_PMTRDT-1:0]                       res_ready;

  rvv_pmtrdt_rs u_rs (
    .clk               (clk),
    .rst_n             (rst_n),
    .uop_valid         (uop_valid),
    .uop_op            (uop_op),
    .uop_vs1           (uop_vs1),
    .uop_vs2           (uop_vs2),
    .uop_rob_idx       (uop_rob_idx),
    .uop_ready         (uop_ready),
    .rs_op             (rs_op),
    .rs_vs1            (rs_vs1),
    .rs_vs2            (rs_vs2),
    .rs_rob_idx        (rs_rob_idx),
    .fifo_empty        (fifo_empty),
    .fifo_almost_empty (fifo_almost_empty),
    .rs_pop            (rs_pop)
  );

  rvv_pmtrdt u_pmtrdt (
    .clk               (clk),
    .rst_n             (rst_n),
    .rs_op             (rs_op),
    .rs_vs1            (rs_vs1),
    .rs_vs2            (rs_vs2),
    .rs_rob_idx        (rs_rob_idx),
    .fifo_empty        (fifo_empty),
    .fifo_almost_empty (fifo_almost_empty),
    .rs_pop            (rs_pop),
    .res_valid         (res_valid),
    .res_data          (res_data),
    .res_rob_idx       (res_rob_idx),
    .res_ready         (res_ready)
  );

  // single ROB write port
  rvv_rob_wb_arb u_wb_arb (
    .clk               (clk),
    .rst_n             (rst_n),
    .res_valid         (res_valid),
    .res_data          (res_data),
    .res_rob_idx       (res_rob_idx),
    .res_ready         (res_ready),
    .result_valid      (result_valid),
    .result_data       (result_data),
    .result_rob_idx    (result_rob_idx),
    .result_ready      (result_ready)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_pmtrdt_model.svh ====
// reference model and random source for the testbench
// include inside a module body that imports rvv_pmtrdt_pkg

`ifndef TB_PMTRDT_MODEL_SVH
`define TB_PMTRDT_MODEL_SVH

// element e of a register as a signed number
function automatic int elem(input logic [`VLEN-1:0] v, input int e);
  logic signed [`SEW-1:0] b;
  b = v[e*`SEW +: `SEW];
  return int'(b);
endfunction

// expected ROB write data for one uop
function automatic logic [`VLEN-1:0] expected_result(
  input pmtrdt_op_e       op,
  input logic [`VLEN-1:0] vs1,
  input logic [`VLEN-1:0] vs2
);
  logic [`VLEN-1:0] res;
  int acc;
  int n;
  res = '0;
  n   = 0;
  acc = elem(vs1, 0);
  case (op)
    OP_VMSEQ: begin
      for (int e = 0; e < `VLMAX; e++) begin
        res[e] = (elem(vs2, e) == elem(vs1, e));
      end
    end
    OP_VMSLT: begin
      // vs2 below vs1, signed
      for (int e = 0; e < `VLMAX; e++) begin
        res[e] = (elem(vs2, e) < elem(vs1, e));
      end
    end
    OP_VREDSUM: begin
      for (int e = 0; e < `VLMAX; e++) begin
        acc = acc + elem(vs2, e);
      end
      // low bits of the int sum give the 8-bit wrap
      res[`SEW-1:0] = acc[`SEW-1:0];
    end
    OP_VREDMAX: begin
      for (int e = 0; e < `VLMAX; e++) begin
        if (elem(vs2, e) > acc) begin
          acc = elem(vs2, e);
        end
      end
      res[`SEW-1:0] = acc[`SEW-1:0];
    end
    OP_VCOMPRESS: begin
      // vs1 low bits pick vs2 elements, packed from element 0 up
      for (int e = 0; e < `VLMAX; e++) begin
        if (vs1[e]) begin
          res[n*`SEW +: `SEW] = vs2[e*`SEW +: `SEW];
          n++;
        end
      end
    end
    default: res = '0;
  endcase
  return res;
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

`endif

// ==== testbench/tb_rvv_pmtrdt_top.sv ====
// random uops through the permutation/reduction path checked per rob_idx
// a rob_idx is reused only after its result came back

`default_nettype none

`include "rvv_pmtrdt_defines.svh"

module tb_rvv_pmtrdt_top;
  import rvv_pmtrdt_pkg::*;

  `include "tb_pmtrdt_model.svh"

  localparam int NUM_TESTS      = 5;
  localparam int UOPS_PER_TEST  = 64;
  // worst case per uop with the ROB port stalled half the time
  localparam int CYCLES_PER_UOP = 12;
  localparam int MAX_CYCLES     = NUM_TESTS * UOPS_PER_TEST * CYCLES_PER_UOP + 1160;
  localparam int NUM_IDX        = 1 << `ROB_IDX_W;
  // station entries plus two stages in each unit
  localparam int MAX_IN_FLIGHT  = `PMTRDT_RS_DEPTH + 2 * `NUM_PMTRDT;
  localparam int DRAIN_LIMIT    = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  uop_valid;
  pmtrdt_op_e            uop_op;
  logic [`VLEN-1:0]      uop_vs1;
  logic [`VLEN-1:0]      uop_vs2;
  logic [`ROB_IDX_W-1:0] uop_rob_idx;
  logic                  uop_ready;
  logic                  result_valid;
  logic [`VLEN-1:0]      result_data;
  logic [`ROB_IDX_W-1:0] result_rob_idx;
  logic                  result_ready;

  // scoreboard with one slot per rob_idx
  logic [`VLEN-1:0]      exp_data    [NUM_IDX];
  logic                  outstanding [NUM_IDX];
  logic [31:0]           rng;
  logic                  held_valid;
  logic [`VLEN-1:0]      held_data;
  logic [`ROB_IDX_W-1:0] held_rob_idx;
  string                 cur_test;
  int                    cycle_count;
  int                    error_count;
  int                    check_count;
  int                    tests_run;
  int                    tests_ok;

  rvv_pmtrdt_top i_rvv_pmtrdt_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .uop_valid      (uop_valid),
    .uop_op         (uop_op),
    .uop_vs1        (uop_vs1),
    .uop_vs2        (uop_vs2),
    .uop_rob_idx    (uop_rob_idx),
    .uop_ready      (uop_ready),
    .result_valid   (result_valid),
    .result_data    (result_data),
    .result_rob_idx (result_rob_idx),
    .result_ready   (result_ready)
  );

  always #5 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles in %s", cycle_count, cur_test);
      $display("test failed");
      $finish;
    end
  end

  // record the expected value at dispatch accept
  always @(posedge clk) begin
    if (rst_n && uop_valid && uop_ready) begin
      exp_data[uop_rob_idx]    = expected_result(uop_op, uop_vs1, uop_vs2);
      outstanding[uop_rob_idx] = 1'b1;
    end
  end

  // compare every ROB port transfer
  always @(posedge clk) begin
    if (rst_n) begin
      // an offered result stays put until it is taken
      if (held_valid && (!result_valid || result_data !== held_data ||
                         result_rob_idx !== held_rob_idx)) begin
        $display("%s: result for rob_idx %0d changed before it was taken",
                 cur_test, held_rob_idx);
        error_count++;
      end
      held_valid   = result_valid && !result_ready;
      held_data    = result_data;
      held_rob_idx = result_rob_idx;
      if (result_valid && result_ready) begin
        check_count++;
        if (!outstanding[result_rob_idx]) begin
          $display("%s: result for rob_idx %0d that is not outstanding",
                   cur_test, result_rob_idx);
          error_count++;
        end else if (result_data != exp_data[result_rob_idx]) begin
          $display("FAILED %s rob_idx %0d expected %h actual %h", cur_test,
                   result_rob_idx, exp_data[result_rob_idx], result_data);
          error_count++;
        end
        outstanding[result_rob_idx] = 1'b0;
      end
    end
  end

  function automatic logic [31:0] draw();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < NUM_IDX; i++) begin
      if (outstanding[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  // random free rob_idx or -1 when all are in flight
  function automatic int free_idx();
    logic [31:0] r;
    int          k;
    r = draw();
    for (int i = 0; i < NUM_IDX; i++) begin
      k = (int'(r[`ROB_IDX_W-1:0]) + i) % NUM_IDX;
      if (!outstanding[k]) begin
        return k;
      end
    end
    return -1;
  endfunction

  // op_mode 1 makes half the uops compress
  task automatic drive_new_uop(input int op_mode);
    int               idx;
    logic [31:0]      r;
    logic [`VLEN-1:0] a;
    logic [`VLEN-1:0] b;
    idx = free_idx();
    if (idx < 0) begin
      uop_valid = 1'b0;
    end else begin
      r = draw();
      a = draw();
      b = draw();
      // copy some vs1 elements so compares also see equal pairs
      for (int e = 0; e < `VLMAX; e++) begin
        if (r[8+e]) begin
          b[e*`SEW +: `SEW] = a[e*`SEW +: `SEW];
        end
      end
      if (op_mode == 1 && r[0]) begin
        uop_op = OP_VCOMPRESS;
      end else begin
        uop_op = pmtrdt_op_e'({1'b0, r[2:1]});
      end
      uop_valid   = 1'b1;
      uop_vs1     = a;
      uop_vs2     = b;
      uop_rob_idx = idx[`ROB_IDX_W-1:0];
    end
  endtask

  // wait for all results and print one line for the test
  task automatic drain_and_report(input string name, input int errors_before);
    int waited;
    result_ready = 1'b1;
    waited       = 0;
    while (pending_count() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pending_count() != 0) begin
      $display("%s: %0d results never came back", name, pending_count());
      error_count++;
    end
    tests_run++;
    if (error_count == errors_before) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic run_idle(input string name);
    int errors_before;
    cur_test      = name;
    errors_before = error_count;
    repeat (20) begin
      @(posedge clk);
      if (result_valid) begin
        $display("%s: result_valid high with nothing dispatched", name);
        error_count++;
      end
      if (!uop_ready) begin
        $display("%s: uop_ready low with an empty station", name);
        error_count++;
      end
    end
    #1;
    drain_and_report(name, errors_before);
  endtask

  task automatic run_stream(input string name, input int op_mode, input bit random_ready);
    int          sent;
    int          errors_before;
    bit          hold;
    logic [31:0] r;
    cur_test      = name;
    errors_before = error_count;
    sent          = 0;
    while (sent < UOPS_PER_TEST) begin
      @(posedge clk);
      // payload stays put until it is taken
      hold = uop_valid && !uop_ready;
      if (uop_valid && uop_ready) begin
        sent++;
      end
      #1;
      if (random_ready) begin
        r            = draw();
        result_ready = r[3];
      end
      if (!hold) begin
        if (sent < UOPS_PER_TEST) begin
          drive_new_uop(op_mode);
        end else begin
          uop_valid = 1'b0;
        end
      end
    end
    drain_and_report(name, errors_before);
  endtask

  // ROB port stalled until the station refuses uops
  task automatic run_backpressure(input string name);
    int sent;
    int waited;
    int errors_before;
    bit dropped;
    bit taken;
    cur_test      = name;
    errors_before = error_count;
    sent          = 0;
    waited        = 0;
    dropped       = 1'b0;
    result_ready  = 1'b0;
    drive_new_uop(0);
    while (!dropped && waited < UOPS_PER_TEST) begin
      @(posedge clk);
      if (uop_valid && uop_ready) begin
        sent++;
      end
      dropped = uop_valid && !uop_ready;
      #1;
      waited++;
      if (!dropped) begin
        drive_new_uop(0);
      end
    end
    if (!dropped) begin
      $display("%s: uop_ready never dropped with the ROB port stalled", name);
      error_count++;
    end else if (sent > MAX_IN_FLIGHT) begin
      $display("%s: %0d uops taken with room for %0d", name, sent, MAX_IN_FLIGHT);
      error_count++;
    end
    // nothing more may get in while still stalled
    repeat (16) begin
      @(posedge clk);
      taken = uop_valid && uop_ready;
      #1;
      if (taken) begin
        $display("%s: uop taken while every stage was full", name);
        error_count++;
        uop_valid = 1'b0;
      end
    end
    // the waiting uop goes in once the release frees room
    result_ready = 1'b1;
    while (uop_valid) begin
      @(posedge clk);
      taken = uop_valid && uop_ready;
      #1;
      if (taken) begin
        uop_valid = 1'b0;
      end
    end
    drain_and_report(name, errors_before);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    uop_valid    = 1'b0;
    uop_op       = OP_VMSEQ;
    uop_vs1      = '0;
    uop_vs2      = '0;
    uop_rob_idx  = '0;
    result_ready = 1'b0;
    rng          = 32'h9aef_ff53;
    held_valid   = 1'b0;
    held_data    = '0;
    held_rob_idx = '0;
    cur_test     = "reset";
    cycle_count  = 0;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_ok     = 0;
    for (int i = 0; i < NUM_IDX; i++) begin
      outstanding[i] = 1'b0;
      exp_data[i]    = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n        = 1'b1;
    result_ready = 1'b1;

    run_idle("idle_after_reset");
    run_stream("cmp_red_stream", 0, 1'b0);
    run_stream("compress_mix", 1, 1'b0);
    run_stream("random_rob_ready", 1, 1'b1);
    run_backpressure("rob_stall_fill");

    $display("%0d of %0d tests ok, %0d results checked, %0d errors",
             tests_ok, tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rvv_pmtrdt_top.f ====
+incdir+hw
+incdir+testbench
hw/rvv_pmtrdt_pkg.sv
hw/rvv_pmtrdt_rs.sv
hw/rvv_pmtrdt_unit.sv
hw/rvv_pmtrdt.sv
hw/rvv_rob_wb_arb.sv
hw/rvv_pmtrdt_top.sv
testbench/tb_rvv_pmtrdt_top.sv

// ==== Makefile ====
# Verilator build and run for the permutation/reduction path

VERILATOR ?= verilator
TOP       ?= tb_rvv_pmtrdt_top
FILELIST  ?= rvv_pmtrdt_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
